//--- Bender.yml
package:
  name: lane_ex1

sources:
  - source/laneExPkg.sv
  - source/laneConverter.sv
  - source/laneShifter.sv
  - source/laneResultMux.sv
  - source/laneExControl.sv
  - source/laneEx1Top.sv
  - target: simulation
    files:
      - tb/laneEx1_sva.sv
      - tb/laneEx1Tb.sv

//--- laneEx1Top.f
source/laneExPkg.sv
source/laneConverter.sv
source/laneShifter.sv
source/laneResultMux.sv
source/laneExControl.sv
source/laneEx1Top.sv
tb/laneEx1_sva.sv
tb/laneEx1Tb.sv

//--- source/laneConverter.sv
`timescale 1ns/1ps

module laneConverter (
	input laneExPkg::laneWord value,
	input logic [2:0] mode,
	output laneExPkg::laneWord result
);

	always_comb begin
		case (mode)
			laneExPkg::CNV_EXTSB[2:0]:
				result = {{56{value[7]}}, value[7:0]};
			laneExPkg::CNV_EXTUB[2:0]:
				result = {56'b0, value[7:0]};
			laneExPkg::CNV_EXTSW[2:0]:
				result = {{48{value[15]}}, value[15:0]};
			laneExPkg::CNV_EXTUW[2:0]:
				result = {48'b0, value[15:0]};
			laneExPkg::CNV_EXTSL[2:0]:
				result = {{32{value[31]}}, value[31:0]};
			laneExPkg::CNV_EXTUL[2:0]:
				result = {32'b0, value[31:0]};
			default:
				result = value; // Codes 6 and 7 pass through
		endcase
	end

endmodule

//--- source/laneEx1Top.sv
`timescale 1ns/1ps

module laneEx1Top (
	input logic clock,
	input logic rst,
	input laneExPkg::laneUop uop,
	input laneExPkg::laneSrc src,
	input laneExPkg::laneImm imm,
	input logic braFlush,
	input logic srT,
	output laneExPkg::laneRegId destId,
	output laneExPkg::laneWord destVal,
	output laneExPkg::laneRegId heldId,
	output logic exHold,
	output laneExPkg::laneFault faultCause
);

	laneExPkg::laneCtrl ctrl;
	laneExPkg::laneWord convVal;
	logic [31:0] shift32;
	laneExPkg::laneWord shift64;

	laneExControl u_control (
		.clock(clock),
		.rst(rst),
		.uop(uop),
		.braFlush(braFlush),
		.srT(srT),
		.idRm(src.idRm),
		.ctrl(ctrl),
		.heldId(heldId),
		.exHold(exHold),
		.faultCause(faultCause)
	);

	laneShifter u_shifter (
		.value(src.valRs),
		.count(src.valRt[7:0]), // Low byte of Rt is the signed count
		.arith(ctrl.shiftArith),
		.shift32(shift32),
		.shift64(shift64)
	);

	laneConverter u_converter (
		.value(src.valRs),
		.mode(ctrl.cnvMode),
		.result(convVal)
	);

	laneResultMux u_resultMux (
		.ctrl(ctrl),
		.src(src),
		.imm(imm),
		.srT(srT),
		.conv(convVal),
		.shift32(shift32),
		.shift64(shift64),
		.destId(destId),
		.destVal(destVal)
	);

endmodule

//--- source/laneExControl.sv
`timescale 1ns/1ps

module laneExControl (
	input logic clock,
	input logic rst,
	input laneExPkg::laneUop uop,
	input logic braFlush,
	input logic srT,
	input laneExPkg::laneRegId idRm,
	output laneExPkg::laneCtrl ctrl,
	output laneExPkg::laneRegId heldId,
	output logic exHold,
	output laneExPkg::laneFault faultCause
);

	logic opEnable;
	laneExPkg::laneUCmd uCmd;
	laneExPkg::laneFault faultNow; // Fault raised by the current op

	always_comb begin
		case (uop.cond)
			laneExPkg::COND_AL: opEnable = 1'b1;
			laneExPkg::COND_NV: opEnable = 1'b0;
			laneExPkg::COND_CT: opEnable = srT;
			laneExPkg::COND_CF: opEnable = !srT;
			default: opEnable = 1'b0;
		endcase
		if (braFlush)
			opEnable = 1'b0; // Flushed op never executes
	end

	assign uCmd = opEnable ? uop.uCmd : laneExPkg::NOP;

	always_comb begin
		ctrl.resSel = laneExPkg::SEL_NONE;
		ctrl.destValid = 1'b0;
		ctrl.immMode = 2'b00;
		ctrl.cnvMode = 3'b000;
		ctrl.shiftArith = 1'b0;
		heldId = laneExPkg::REG_ZZR;
		faultNow = laneExPkg::FLT_NONE;

		case (uCmd)
			laneExPkg::NOP, laneExPkg::LEA_MR, laneExPkg::MOV_MR,
			laneExPkg::POPX, laneExPkg::ALUCMP, laneExPkg::MUL3: begin
			end
			laneExPkg::INVOP: faultNow = laneExPkg::FLT_INVOP;
			laneExPkg::MOV_RM: ctrl.resSel = laneExPkg::SEL_RS; // Store data only
			laneExPkg::PUSHX: ctrl.resSel = laneExPkg::SEL_RM;
			laneExPkg::ALU3, laneExPkg::UNARY, laneExPkg::ALUW3,
			laneExPkg::MULW3, laneExPkg::FPU3:
				heldId = idRm; // Resolved in a later stage
			laneExPkg::CONV_RR: begin
				ctrl.resSel = laneExPkg::SEL_CONV;
				ctrl.destValid = 1'b1;
				// Unknown sub-ops map onto the pass-through code
				ctrl.cnvMode = (uop.uIxt > laneExPkg::CNV_EXTUL) ? 3'd7 : uop.uIxt[2:0];
			end
			laneExPkg::MOV_IR: begin
				ctrl.destValid = 1'b1;
				if (uop.uIxt > laneExPkg::IMM_SH32) begin
					ctrl.resSel = laneExPkg::SEL_RT; // Unknown form copies Rt
				end else begin
					ctrl.resSel = laneExPkg::SEL_IMM;
					ctrl.immMode = uop.uIxt[1:0];
				end
			end
			laneExPkg::SHAD3, laneExPkg::SHLD3: begin
				ctrl.resSel = (uCmd == laneExPkg::SHAD3) ?
					laneExPkg::SEL_SHAD32 : laneExPkg::SEL_SHLD32;
				ctrl.destValid = 1'b1;
				ctrl.shiftArith = (uCmd == laneExPkg::SHAD3);
			end
			laneExPkg::SHADQ3, laneExPkg::SHLDQ3: begin
				ctrl.resSel = laneExPkg::SEL_SHIFT64;
				ctrl.destValid = 1'b1;
				ctrl.shiftArith = (uCmd == laneExPkg::SHADQ3);
			end
			laneExPkg::OP_IXS: begin
				case (uop.uIxt)
					laneExPkg::IXS_NOP: begin
					end
					laneExPkg::IXS_MOVT: begin
						ctrl.resSel = laneExPkg::SEL_TBIT;
						ctrl.destValid = 1'b1;
					end
					laneExPkg::IXS_MOVNT: begin
						ctrl.resSel = laneExPkg::SEL_NTBIT;
						ctrl.destValid = 1'b1;
					end
					default: faultNow = laneExPkg::FLT_IXS;
				endcase
			end
			laneExPkg::OP_IXT: begin
				case (uop.uIxt)
					laneExPkg::IXT_NOP, laneExPkg::IXT_SLEEP: begin
					end
					laneExPkg::IXT_BREAK: faultNow = laneExPkg::FLT_BREAK;
					default: faultNow = laneExPkg::FLT_IXT;
				endcase
			end
			default: faultNow = laneExPkg::FLT_UCMD; // Opcode not handled in this lane
		endcase
	end

	// Hold stays low throughout reset
	assign exHold = (faultNow != laneExPkg::FLT_NONE) && !rst;

	// Keeps the first fault seen since reset
	always_ff @(posedge clock) begin
		if (rst) begin
			faultCause <= laneExPkg::FLT_NONE;
		end else if (faultCause == laneExPkg::FLT_NONE) begin
			faultCause <= faultNow;
		end
	end

endmodule

//--- source/laneExPkg.sv
package laneExPkg;

	localparam int WORD_W = 64;
	localparam int REGID_W = 6;
	localparam int IMM_W = 33;

	typedef logic [WORD_W-1:0] laneWord;
	typedef logic [REGID_W-1:0] laneRegId;
	typedef logic [IMM_W-1:0] laneImm; // Bit 32 carries the payload sign
	typedef logic [5:0] laneIxt;

	localparam laneRegId REG_ZZR = '1; // No destination

	typedef enum logic [1:0] {
		COND_AL, // Always
		COND_NV, // Never
		COND_CT, // If T set
		COND_CF  // If T clear
	} laneCond;

	typedef enum logic [5:0] {
		NOP, INVOP, LEA_MR, MOV_RM, MOV_MR, PUSHX, POPX,
		ALU3, UNARY, ALUW3, ALUCMP, MULW3, MUL3, FPU3,
		CONV_RR, MOV_IR, SHAD3, SHLD3, SHADQ3, SHLDQ3,
		OP_IXS, OP_IXT
	} laneUCmd;

	// OP_IXS sub-ops
	localparam laneIxt IXS_NOP = 6'h00;
	localparam laneIxt IXS_MOVT = 6'h01;
	localparam laneIxt IXS_MOVNT = 6'h02;

	// OP_IXT sub-ops
	localparam laneIxt IXT_NOP = 6'h00;
	localparam laneIxt IXT_SLEEP = 6'h01;
	localparam laneIxt IXT_BREAK = 6'h02;

	// CONV_RR sub-ops
	localparam laneIxt CNV_EXTSB = 6'h00;
	localparam laneIxt CNV_EXTUB = 6'h01;
	localparam laneIxt CNV_EXTSW = 6'h02;
	localparam laneIxt CNV_EXTUW = 6'h03;
	localparam laneIxt CNV_EXTSL = 6'h04;
	localparam laneIxt CNV_EXTUL = 6'h05;

	// MOV_IR sub-ops
	localparam laneIxt IMM_LDI = 6'h00;
	localparam laneIxt IMM_SH8 = 6'h01;
	localparam laneIxt IMM_SH16 = 6'h02;
	localparam laneIxt IMM_SH32 = 6'h03;

	typedef struct packed {
		laneCond cond;
		laneUCmd uCmd;
		laneIxt uIxt;
	} laneUop;

	typedef struct packed {
		laneRegId idRs;
		laneRegId idRt;
		laneRegId idRm;
		laneWord valRs;
		laneWord valRt;
		laneWord valRm;
	} laneSrc;

	typedef enum logic [3:0] {
		SEL_NONE, SEL_RS, SEL_RM, SEL_RT, SEL_IMM, SEL_CONV,
		SEL_SHAD32, SEL_SHLD32, SEL_SHIFT64, SEL_TBIT, SEL_NTBIT
	} laneResSel;

	typedef struct packed {
		laneResSel resSel;
		logic destValid;  // Result written to idRm
		logic [1:0] immMode;
		logic [2:0] cnvMode;
		logic shiftArith;
	} laneCtrl;

	typedef enum logic [2:0] {
		FLT_NONE, FLT_INVOP, FLT_UCMD, FLT_IXS, FLT_IXT, FLT_BREAK
	} laneFault;

endpackage

//--- source/laneResultMux.sv
`timescale 1ns/1ps

module laneResultMux (
	input laneExPkg::laneCtrl ctrl,
	input laneExPkg::laneSrc src,
	input laneExPkg::laneImm imm,
	input logic srT,
	input laneExPkg::laneWord conv,
	input logic [31:0] shift32,
	input laneExPkg::laneWord shift64,
	output laneExPkg::laneRegId destId,
	output laneExPkg::laneWord destVal
);

	laneExPkg::laneWord immVal;

	// Immediate loads and shift-ins
	always_comb begin
		case (ctrl.immMode)
			laneExPkg::IMM_SH8[1:0]:
				immVal = {src.valRs[55:0], imm[7:0]};
			laneExPkg::IMM_SH16[1:0]:
				immVal = {src.valRs[47:0], imm[15:0]};
			laneExPkg::IMM_SH32[1:0]:
				immVal = {src.valRs[31:0], imm[31:0]};
			default:
				immVal = {{31{imm[32]}}, imm}; // LDI sign-extends from bit 32
		endcase
	end

	always_comb begin
		case (ctrl.resSel)
			laneExPkg::SEL_RS: destVal = src.valRs;
			laneExPkg::SEL_RM: destVal = src.valRm;
			laneExPkg::SEL_RT: destVal = src.valRt;
			laneExPkg::SEL_IMM: destVal = immVal;
			laneExPkg::SEL_CONV: destVal = conv;
			laneExPkg::SEL_SHAD32: destVal = {{32{shift32[31]}}, shift32};
			laneExPkg::SEL_SHLD32: destVal = {32'b0, shift32};
			laneExPkg::SEL_SHIFT64: destVal = shift64;
			laneExPkg::SEL_TBIT: destVal = {63'b0, srT};
			laneExPkg::SEL_NTBIT: destVal = {63'b0, !srT};
			default: destVal = '0;
		endcase
	end

	// Store data leaves destValid clear so no register is named
	assign destId = ctrl.destValid ? src.idRm : laneExPkg::REG_ZZR;

endmodule

//--- source/laneShifter.sv
`timescale 1ns/1ps

module laneShifter (
	input laneExPkg::laneWord value,
	input logic [7:0] count,
	input logic arith,
	output logic [31:0] shift32,
	output laneExPkg::laneWord shift64
);

	logic shiftLeft;
	logic [7:0] amount;      // Magnitude of the shift, 0 to 128
	laneExPkg::laneWord low32Ext;
	laneExPkg::laneWord wide32;

	// Shift with saturation once the amount reaches the word width
	function automatic laneExPkg::laneWord shiftWord(
		input laneExPkg::laneWord v,
		input logic left,
		input logic [7:0] amt,
		input logic fillSign
	);
		laneExPkg::laneWord fill;
		laneExPkg::laneWord res;
		fill = (fillSign && v[63]) ? '1 : '0;
		if (left) begin
			res = (amt >= 8'd64) ? '0 : (v << amt[5:0]);
		end else if (amt >= 8'd64) begin
			res = fill;
		end else if (fillSign) begin
			res = laneExPkg::laneWord'($signed(v) >>> amt[5:0]);
		end else begin
			res = v >> amt[5:0];
		end
		return res;
	endfunction

	assign shiftLeft = !count[7]; // Count is a signed byte
	assign amount = shiftLeft ? count : (8'd0 - count);

	// The upper half mirrors bit 31 so right shifts fill as in a 32-bit word
	assign low32Ext = arith ? {{32{value[31]}}, value[31:0]} : {32'b0, value[31:0]};

	assign shift64 = shiftWord(value, shiftLeft, amount, arith);
	assign wide32 = shiftWord(low32Ext, shiftLeft, amount, arith);
	assign shift32 = wide32[31:0];

endmodule

//--- tb/laneEx1Tb.sv
`timescale 1ns/1ps

module laneEx1Tb;

	// Reset, conditions, shifts, moves, held ops, faults
	localparam int TEST_CYCLES = 17 + 16 + 136 + 18 + 5 + 6;
	localparam int CYCLE_LIMIT = 4 * TEST_CYCLES;

	typedef struct packed {
		laneExPkg::laneRegId destId;
		laneExPkg::laneWord destVal;
		laneExPkg::laneRegId heldId;
		laneExPkg::laneFault fault;
	} expRes;

	logic clock = 1'b0;
	logic rst;
	laneExPkg::laneUop uop;
	laneExPkg::laneSrc src;
	laneExPkg::laneImm imm;
	logic braFlush;
	logic srT;
	laneExPkg::laneRegId destId;
	laneExPkg::laneWord destVal;
	laneExPkg::laneRegId heldId;
	logic exHold;
	laneExPkg::laneFault faultCause;

	int errors = 0;
	int cycles = 0;
	logic [31:0] rngState = 32'd37447;
	laneExPkg::laneFault faultExp; // Expected sticky cause

	laneEx1Top u_dut (
		.clock(clock),
		.rst(rst),
		.uop(uop),
		.src(src),
		.imm(imm),
		.braFlush(braFlush),
		.srT(srT),
		.destId(destId),
		.destVal(destVal),
		.heldId(heldId),
		.exHold(exHold),
		.faultCause(faultCause)
	);

	always #10 clock = !clock;

	function automatic logic [31:0] nextRand();
		rngState ^= rngState << 13;
		rngState ^= rngState >> 17;
		rngState ^= rngState << 5;
		return rngState;
	endfunction

	function automatic laneExPkg::laneSrc randSrc();
		laneExPkg::laneSrc s;
		s.idRs = laneExPkg::laneRegId'(nextRand() % 63); // Never the ZZR id
		s.idRt = laneExPkg::laneRegId'(nextRand() % 63);
		s.idRm = laneExPkg::laneRegId'(nextRand() % 63);
		s.valRs = {nextRand(), nextRand()};
		s.valRt = {nextRand(), nextRand()};
		s.valRm = {nextRand(), nextRand()};
		return s;
	endfunction

	function automatic laneExPkg::laneImm randImm();
		logic [31:0] hi;
		hi = nextRand();
		return {hi[0], nextRand()};
	endfunction

	function automatic laneExPkg::laneUop makeUop(input laneExPkg::laneCond c,
			input laneExPkg::laneUCmd op, input laneExPkg::laneIxt ix);
		laneExPkg::laneUop u;
		u.cond = c;
		u.uCmd = op;
		u.uIxt = ix;
		return u;
	endfunction

	// Bit-at-a-time shift of a w-bit word by a signed byte count
	function automatic laneExPkg::laneWord shiftRef(input laneExPkg::laneWord v, input int w,
			input logic [7:0] cnt, input logic arith);
		laneExPkg::laneWord r;
		logic s;
		int n;
		n = $signed(cnt);
		r = (w == 32) ? {32'b0, v[31:0]} : v;
		s = arith && r[w-1];
		for (int i = 0; i < n; i++)
			r = r << 1;
		for (int i = 0; i < -n; i++) begin
			r = r >> 1;
			r[w-1] = s;
		end
		if (w == 32)
			r = {32'b0, r[31:0]};
		return r;
	endfunction

	function automatic expRes model(input laneExPkg::laneUop u, input laneExPkg::laneSrc s,
			input laneExPkg::laneImm im, input logic flush, input logic t);
		expRes e;
		logic en;
		int k;
		laneExPkg::laneWord r;
		e.destId = laneExPkg::REG_ZZR;
		e.destVal = '0;
		e.heldId = laneExPkg::REG_ZZR;
		e.fault = laneExPkg::FLT_NONE;
		en = !flush && (u.cond == laneExPkg::COND_AL || (u.cond == laneExPkg::COND_CT && t)
			|| (u.cond == laneExPkg::COND_CF && !t));
		if (!en)
			return e;
		case (u.uCmd)
			laneExPkg::NOP, laneExPkg::LEA_MR, laneExPkg::MOV_MR, laneExPkg::POPX,
			laneExPkg::ALUCMP, laneExPkg::MUL3: ;
			laneExPkg::INVOP: e.fault = laneExPkg::FLT_INVOP;
			laneExPkg::MOV_RM: e.destVal = s.valRs;
			laneExPkg::PUSHX: e.destVal = s.valRm;
			laneExPkg::ALU3, laneExPkg::UNARY, laneExPkg::ALUW3, laneExPkg::MULW3,
			laneExPkg::FPU3: e.heldId = s.idRm;
			laneExPkg::CONV_RR: begin
				e.destId = s.idRm;
				e.destVal = s.valRs;
				if (u.uIxt < 6) begin
					k = 64 - (8 << (u.uIxt >> 1)); // Field moved to the top, then back
					r = s.valRs << k;
					if (u.uIxt[0])
						e.destVal = r >> k;
					else
						e.destVal = $signed(r) >>> k;
				end
			end
			laneExPkg::MOV_IR: begin
				e.destId = s.idRm;
				if (u.uIxt == laneExPkg::IMM_LDI) begin
					e.destVal = im;
					if (im[32])
						e.destVal = e.destVal | ~((64'd1 << 33) - 64'd1);
				end else if (u.uIxt <= laneExPkg::IMM_SH32) begin
					k = 4 << u.uIxt;
					e.destVal = (s.valRs << k) | ({31'b0, im} & ((64'd1 << k) - 64'd1));
				end else begin
					e.destVal = s.valRt;
				end
			end
			laneExPkg::SHAD3, laneExPkg::SHLD3: begin
				e.destId = s.idRm;
				r = shiftRef(s.valRs, 32, s.valRt[7:0], u.uCmd == laneExPkg::SHAD3);
				if (u.uCmd == laneExPkg::SHAD3 && r[31])
					r = r | 64'hFFFF_FFFF_0000_0000;
				e.destVal = r;
			end
			laneExPkg::SHADQ3, laneExPkg::SHLDQ3: begin
				e.destId = s.idRm;
				e.destVal = shiftRef(s.valRs, 64, s.valRt[7:0], u.uCmd == laneExPkg::SHADQ3);
			end
			laneExPkg::OP_IXS: begin
				if (u.uIxt == laneExPkg::IXS_MOVT || u.uIxt == laneExPkg::IXS_MOVNT) begin
					e.destId = s.idRm;
					e.destVal = (u.uIxt == laneExPkg::IXS_MOVT) ? t : !t;
				end else if (u.uIxt != laneExPkg::IXS_NOP) begin
					e.fault = laneExPkg::FLT_IXS;
				end
			end
			laneExPkg::OP_IXT: begin
				if (u.uIxt == laneExPkg::IXT_BREAK)
					e.fault = laneExPkg::FLT_BREAK;
				else if (u.uIxt > laneExPkg::IXT_BREAK)
					e.fault = laneExPkg::FLT_IXT;
			end
			default: e.fault = laneExPkg::FLT_UCMD;
		endcase
		return e;
	endfunction

	task automatic checkWord(input string name, input laneExPkg::laneWord got,
			input laneExPkg::laneWord exp);
		if (got !== exp) begin
			$display("CHECK FAILED %s: got 0x%h, expected 0x%h", name, got, exp);
			errors++;
		end
	endtask

	task automatic checkRegId(input string name, input laneExPkg::laneRegId got,
			input laneExPkg::laneRegId exp);
		if (got !== exp) begin
			$display("CHECK FAILED %s: got 0x%h, expected 0x%h", name, got, exp);
			errors++;
		end
	endtask

	task automatic checkFault(input string name, input laneExPkg::laneFault got,
			input laneExPkg::laneFault exp);
		if (got !== exp) begin
			$display("CHECK FAILED %s: got 0x%h, expected 0x%h", name, got, exp);
			errors++;
		end
	endtask

	task automatic checkBit(input string name, input logic got, input logic exp);
		if (got !== exp) begin
			$display("CHECK FAILED %s: got 0x%h, expected 0x%h", name, got, exp);
			errors++;
		end
	endtask

	// Enters 2 ns after a rising edge and returns at that point one cycle later
	task automatic runOp(input laneExPkg::laneUop u, input laneExPkg::laneSrc s,
			input laneExPkg::laneImm im, input logic flush, input logic t);
		expRes e;
		e = model(u, s, im, flush, t);
		uop = u;
		src = s;
		imm = im;
		braFlush = flush;
		srT = t;
		@(negedge clock); // Outputs settled mid-cycle
		checkRegId("destId", destId, e.destId);
		checkWord("destVal", destVal, e.destVal);
		checkRegId("heldId", heldId, e.heldId);
		checkBit("exHold", exHold, e.fault != laneExPkg::FLT_NONE);
		checkFault("faultCause", faultCause, faultExp);
		if (faultExp == laneExPkg::FLT_NONE)
			faultExp = e.fault; // Captured at the coming edge
		@(posedge clock);
		#2;
	endtask

	task automatic resetSequence();
		uop = makeUop(laneExPkg::COND_AL, laneExPkg::OP_IXT, laneExPkg::IXT_BREAK);
		repeat (16) begin
			@(negedge clock);
			checkBit("exHold", exHold, 1'b0); // Fault masked in reset
			checkFault("faultCause", faultCause, laneExPkg::FLT_NONE);
			@(posedge clock);
		end
		#2;
		rst = 1'b0;
		faultExp = laneExPkg::FLT_NONE;
		runOp(makeUop(laneExPkg::COND_AL, laneExPkg::NOP, '0), randSrc(), randImm(), 0, 0);
	endtask

	task automatic condFlushSweep();
		for (int c = 0; c < 4; c++)
			for (int t = 0; t < 2; t++)
				for (int f = 0; f < 2; f++)
					runOp(makeUop(laneExPkg::laneCond'(c), laneExPkg::SHLDQ3, '0), randSrc(),
						randImm(), f[0], t[0]);
	endtask

	task automatic shiftSweep();
		int cnts[18] = '{0, 1, 31, 32, 33, 63, 64, 65, 100, 127,
			-1, -31, -32, -33, -63, -64, -65, -128};
		laneExPkg::laneSrc s;
		laneExPkg::laneUCmd op;
		for (int k = 0; k < 4; k++) begin
			op = laneExPkg::laneUCmd'(laneExPkg::SHAD3 + k); // SHAD3 to SHLDQ3
			for (int i = 0; i < 34; i++) begin
				s = randSrc();
				if (i < 18)
					s.valRt[7:0] = cnts[i][7:0]; // Edge counts, then random ones
				runOp(makeUop(laneExPkg::COND_AL, op, '0), s, randImm(), 1'b0, 1'b0);
			end
		end
	endtask

	task automatic moveConvChecks();
		runOp(makeUop(laneExPkg::COND_AL, laneExPkg::MOV_RM, '0), randSrc(), randImm(), 0, 0);
		runOp(makeUop(laneExPkg::COND_AL, laneExPkg::PUSHX, '0), randSrc(), randImm(), 0, 0);
		for (int m = 0; m < 7; m++)
			runOp(makeUop(laneExPkg::COND_AL, laneExPkg::CONV_RR, laneExPkg::laneIxt'(m)),
				randSrc(), randImm(), 0, 0);
		for (int m = 0; m < 5; m++)
			runOp(makeUop(laneExPkg::COND_AL, laneExPkg::MOV_IR, laneExPkg::laneIxt'(m)),
				randSrc(), randImm(), 0, 0);
		for (int t = 0; t < 2; t++) begin
			runOp(makeUop(laneExPkg::COND_AL, laneExPkg::OP_IXS, laneExPkg::IXS_MOVT),
				randSrc(), randImm(), 0, t[0]);
			runOp(makeUop(laneExPkg::COND_AL, laneExPkg::OP_IXS, laneExPkg::IXS_MOVNT),
				randSrc(), randImm(), 0, t[0]);
		end
	endtask

	task automatic heldDestChecks();
		laneExPkg::laneUCmd ops[5] = '{laneExPkg::ALU3, laneExPkg::UNARY, laneExPkg::ALUW3,
			laneExPkg::MULW3, laneExPkg::FPU3};
		foreach (ops[i])
			runOp(makeUop(laneExPkg::COND_AL, ops[i], '0), randSrc(), randImm(), 0, 0);
	endtask

	task automatic faultSequence();
		runOp(makeUop(laneExPkg::COND_AL, laneExPkg::OP_IXT, laneExPkg::IXT_BREAK),
			randSrc(), randImm(), 0, 0);
		runOp(makeUop(laneExPkg::COND_AL, laneExPkg::INVOP, '0), randSrc(), randImm(), 0, 0);
		runOp(makeUop(laneExPkg::COND_AL, laneExPkg::laneUCmd'(6'd50), '0), randSrc(),
			randImm(), 0, 0); // Opcode outside the enum
		runOp(makeUop(laneExPkg::COND_AL, laneExPkg::NOP, '0), randSrc(), randImm(), 0, 0);
		rst = 1'b1;
		@(posedge clock);
		#2;
		rst = 1'b0;
		faultExp = laneExPkg::FLT_NONE;
		runOp(makeUop(laneExPkg::COND_AL, laneExPkg::NOP, '0), randSrc(), randImm(), 0, 0);
	endtask

	initial begin
		rst = 1'b1;
		uop = makeUop(laneExPkg::COND_AL, laneExPkg::NOP, '0);
		src = '0;
		imm = '0;
		braFlush = 1'b0;
		srT = 1'b0;
		faultExp = laneExPkg::FLT_NONE;
		resetSequence();
		condFlushSweep();
		shiftSweep();
		moveConvChecks();
		heldDestChecks();
		faultSequence();
		$display("Check errors: %0d, assertion failures: %0d", errors, u_dut.u_sva.assertFails);
		if (errors == 0 && u_dut.u_sva.assertFails == 0)
			$display("ALL CHECKS PASSED");
		else
			$display("CHECKS FAILED");
		$finish;
	end

	initial begin
		while (cycles < CYCLE_LIMIT) begin
			@(posedge clock);
			cycles++;
		end
		$display("Timeout: tests did not finish within %0d cycles", CYCLE_LIMIT);
		$display("CHECKS FAILED");
		$finish;
	end

endmodule

//--- tb/laneEx1_sva.sv
`timescale 1ns/1ps

module laneEx1Sva (
	input logic clock,
	input logic rst,
	input laneExPkg::laneRegId destId,
	input laneExPkg::laneRegId heldId,
	input logic exHold,
	input laneExPkg::laneFault faultCause
);

	int assertFails = 0; // Read by the testbench for its summary

	holdLowInReset: assert property (@(posedge clock) rst |-> !exHold)
	else begin
		$error("exHold asserted while rst is high");
		assertFails++;
	end

	// Once set, the cause only clears through reset
	faultSticky: assert property (@(posedge clock)
		(!rst && faultCause != laneExPkg::FLT_NONE) |=> $stable(faultCause))
	else begin
		$error("faultCause changed without a reset");
		assertFails++;
	end

	destOrHeld: assert property (@(posedge clock)
		destId != laneExPkg::REG_ZZR |-> heldId == laneExPkg::REG_ZZR)
	else begin
		$error("destId and heldId both name a register");
		assertFails++;
	end

endmodule

bind laneEx1Top laneEx1Sva u_sva (
	.clock(clock),
	.rst(rst),
	.destId(destId),
	.heldId(heldId),
	.exHold(exHold),
	.faultCause(faultCause)
);
